// File: Makefile
# Verilator simulation of the cpu16 testbench

SIM := obj_dir/Vtb_cpu16

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu16 -f src.f
	./$(SIM) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: src.f
src/cpu16_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/cpu_ctrl.sv
src/cpu16_top.sv
verif/cpu16_assertions.sv
verif/tb_cpu16.sv

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire [15:0]              a,
	input  wire [15:0]              b,
	input  wire cpu16_pkg::alu_op_e op,
	output logic [15:0]             y
);

	always_comb begin
		case (op)
			cpu16_pkg::alu_add: begin
				y = a + b; // ADDIU, ADDU, LW/SW address
			end
			cpu16_pkg::alu_sub: begin
				y = a - b;
			end
			cpu16_pkg::alu_and: begin
				y = a & b;
			end
			cpu16_pkg::alu_or: begin
				y = a | b;
			end
			cpu16_pkg::alu_sll: begin
				// Amount is 1..8, four bits are enough
				y = a << b[3:0];
			end
			cpu16_pkg::alu_pass_b: begin
				y = b; // LI and MOVE
			end
			default: begin
				y = 16'h0000;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register file geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int reg_addr_w = 3; // r0..r7

	////////////////////////////////////////////////////////////////////////////
	// Major opcodes, instr[15:11]
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		op_nop    = 5'b00001, // NOP group, 0x0800
		op_b      = 5'b00010, // Unconditional branch, imm11
		op_bnez   = 5'b00101, // Branch if rx != 0, imm8
		op_shift  = 5'b00110, // SLL/SRL/SRA, only SLL kept
		op_addiu  = 5'b01001,
		op_li     = 5'b01101,
		op_move   = 5'b01111,
		op_lw     = 5'b10011, // ry = mem[rx + imm5]
		op_sw     = 5'b11011, // mem[rx + imm5] = ry
		op_addsub = 5'b11100, // ADDU/SUBU, funct in [1:0]
		op_rr     = 5'b11101  // Reg-reg group, funct in [4:0]
	} opcode_e;

	// Minor function fields inside the groups
	localparam logic [1:0] funct_addu = 2'b01;
	localparam logic [1:0] funct_subu = 2'b11;
	localparam logic [1:0] funct_sll  = 2'b00;
	localparam logic [4:0] funct_and  = 5'b01100;
	localparam logic [4:0] funct_or   = 5'b01101;
	localparam logic [4:0] funct_move = 5'b00000;

	////////////////////////////////////////////////////////////////////////////
	// Datapath and control encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_sll,   // a << b
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		br_none,
		br_always,
		br_nez
	} branch_e;

	// Controller FSM
	typedef enum logic [1:0] {
		st_fetch,
		st_exec,
		st_mem,
		st_wback
	} state_e;

endpackage

`default_nettype wire

// File: src/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_top #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  wire         pclk,
	input  wire         arst_n,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [15:0] wb_adr,
	output logic [15:0] wb_dat_w,
	input  wire [15:0]  wb_dat_r,
	input  wire         wb_ack
);

	logic [15:0]                      instr;
	logic [cpu16_pkg::reg_addr_w-1:0] read_addr1;
	logic [cpu16_pkg::reg_addr_w-1:0] read_addr2;
	logic [cpu16_pkg::reg_addr_w-1:0] reg_addr;
	logic                             reg_write;
	logic                             mem_read;
	logic                             mem_write;
	cpu16_pkg::alu_op_e               alu_op;
	logic                             alu_src_imm;
	logic [15:0]                      imm;
	cpu16_pkg::branch_e               branch;
	logic [15:0]                      rd_data1;
	logic [15:0]                      rd_data2;
	logic [15:0]                      alu_b;
	logic [15:0]                      alu_y;
	logic                             wr_en;
	logic [cpu16_pkg::reg_addr_w-1:0] wr_addr;
	logic [15:0]                      wr_data;

	assign alu_b = alu_src_imm ? imm : rd_data2; // Operand B select

	cpu_ctrl #(
		.RESET_PC (RESET_PC)
	) u_ctrl (
		.pclk      (pclk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.reg_write (reg_write),
		.reg_addr  (reg_addr),
		.branch    (branch),
		.imm       (imm),
		.instr     (instr),
		.rd2_data  (rd_data2),
		.rd1_data  (rd_data1),
		.alu_y     (alu_y),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	decoder u_dec (
		.instr       (instr),
		.read_addr1  (read_addr1),
		.read_addr2  (read_addr2),
		.reg_addr    (reg_addr),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.imm         (imm),
		.branch      (branch)
	);

	reg_file u_rf (
		.pclk     (pclk),
		.arst_n   (arst_n),
		.rd_addr1 (read_addr1),
		.rd_addr2 (read_addr2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	alu u_alu (
		.a  (rd_data1),
		.b  (alu_b),
		.op (alu_op),
		.y  (alu_y)
	);

endmodule

`default_nettype wire

// File: src/cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  wire                              pclk,
	input  wire                              arst_n,
	// Wishbone classic master
	output logic                             wb_cyc,
	output logic                             wb_stb,
	output logic                             wb_we,
	output logic [15:0]                      wb_adr,
	output logic [15:0]                      wb_dat_w,
	input  wire [15:0]                       wb_dat_r,
	input  wire                              wb_ack,
	// Decoded control
	input  wire                              mem_read,
	input  wire                              mem_write,
	input  wire                              reg_write,
	input  wire [cpu16_pkg::reg_addr_w-1:0]  reg_addr,
	input  wire cpu16_pkg::branch_e          branch,
	input  wire [15:0]                       imm,
	// Datapath
	output logic [15:0]                      instr,
	input  wire [15:0]                       rd2_data,
	input  wire [15:0]                       rd1_data,
	input  wire [15:0]                       alu_y,
	output logic                             wr_en,
	output logic [cpu16_pkg::reg_addr_w-1:0] wr_addr,
	output logic [15:0]                      wr_data
);

	cpu16_pkg::state_e state;

	logic [15:0] pc;
	logic [15:0] ir;      // Instruction register
	logic [15:0] ld_data; // Load data held for write-back
	logic        bus_req;
	logic        mem_op;
	logic        taken;
	logic [15:0] pc_inc;
	logic [15:0] pc_next;

	assign instr  = ir;
	assign wb_cyc = bus_req; // CYC and STB always move together
	assign wb_stb = bus_req;
	assign mem_op = mem_read | mem_write;

	////////////////////////////////////////////////////////////////////////////
	// Next PC
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (branch)
			cpu16_pkg::br_always: taken = 1'b1;
			cpu16_pkg::br_nez:    taken = (rd1_data != 16'h0000);
			default:              taken = 1'b0;
		endcase
	end

	assign pc_inc  = pc + 16'd1;
	assign pc_next = taken ? pc_inc + imm : pc_inc; // Offset relative to PC+1

	// Register write port, ALU results in exec, loads in wback
	always_comb begin
		wr_en   = 1'b0;
		wr_addr = reg_addr;
		wr_data = alu_y;
		if (state == cpu16_pkg::st_exec) begin
			wr_en = reg_write & ~mem_op;
		end
		else if (state == cpu16_pkg::st_wback) begin
			wr_en   = reg_write;
			wr_data = ld_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM and bus handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= cpu16_pkg::st_fetch;
			pc      <= RESET_PC;
			bus_req <= 1'b0;
			wb_we   <= 1'b0;
		end
		else begin
			case (state)
				cpu16_pkg::st_fetch: begin
					if (!bus_req) begin // Idle cycle over, start fetch
						bus_req <= 1'b1;
						wb_we   <= 1'b0;
					end
					else if (wb_ack) begin
						bus_req <= 1'b0;
						state   <= cpu16_pkg::st_exec;
					end
				end
				cpu16_pkg::st_exec: begin
					pc      <= pc_next;
					bus_req <= 1'b1; // Data access or next fetch
					wb_we   <= mem_write;
					state   <= mem_op ? cpu16_pkg::st_mem : cpu16_pkg::st_fetch;
				end
				cpu16_pkg::st_mem: begin
					if (wb_ack) begin
						bus_req <= 1'b0;
						wb_we   <= 1'b0;
						state   <= mem_read ? cpu16_pkg::st_wback : cpu16_pkg::st_fetch;
					end
				end
				cpu16_pkg::st_wback: begin
					bus_req <= 1'b1; // Fetch overlaps nothing, bus was idle
					wb_we   <= 1'b0;
					state   <= cpu16_pkg::st_fetch;
				end
				default: begin
					state <= cpu16_pkg::st_fetch;
				end
			endcase
		end
	end

	// Address, write data and captured read data
	always_ff @(posedge pclk) begin
		if (state == cpu16_pkg::st_fetch && bus_req && wb_ack) begin
			ir <= wb_dat_r;
		end
		if (state == cpu16_pkg::st_mem && wb_ack) begin
			ld_data <= wb_dat_r; // dat_r only valid with ack
		end
		if (state == cpu16_pkg::st_exec) begin
			wb_adr   <= mem_op ? alu_y : pc_next;
			wb_dat_w <= rd2_data; // ry for SW
		end
		else if (!bus_req) begin
			wb_adr <= pc; // Fetch after reset, SW or wback
		end
	end

endmodule

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  wire [15:0]                           instr,
	output logic [cpu16_pkg::reg_addr_w-1:0]     read_addr1,
	output logic [cpu16_pkg::reg_addr_w-1:0]     read_addr2,
	output logic [cpu16_pkg::reg_addr_w-1:0]     reg_addr,
	output logic                                 reg_write,
	output logic                                 mem_read,
	output logic                                 mem_write,
	output cpu16_pkg::alu_op_e                   alu_op,
	output logic                                 alu_src_imm,
	output logic [15:0]                          imm,
	output cpu16_pkg::branch_e                   branch
);

	cpu16_pkg::opcode_e opcode;

	assign opcode = cpu16_pkg::opcode_e'(instr[15:11]);

	always_comb begin
		// Defaults behave as NOP
		read_addr1  = instr[10:8]; // rx
		read_addr2  = instr[7:5];  // ry
		reg_addr    = instr[10:8];
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		alu_op      = cpu16_pkg::alu_add;
		alu_src_imm = 1'b0;
		imm         = 16'h0000;
		branch      = cpu16_pkg::br_none;

		case (opcode)
			cpu16_pkg::op_addiu: begin // rx += simm8
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = {{8{instr[7]}}, instr[7:0]};
			end
			cpu16_pkg::op_li: begin // rx = zimm8
				reg_write   = 1'b1;
				alu_op      = cpu16_pkg::alu_pass_b;
				alu_src_imm = 1'b1;
				imm         = {8'h00, instr[7:0]};
			end
			cpu16_pkg::op_addsub: begin
				if (instr[1:0] == cpu16_pkg::funct_addu) begin // rz = rx + ry
					reg_addr  = instr[4:2];
					reg_write = 1'b1;
				end
				else if (instr[1:0] == cpu16_pkg::funct_subu) begin // rz = rx - ry
					reg_addr  = instr[4:2];
					reg_write = 1'b1;
					alu_op    = cpu16_pkg::alu_sub;
				end
			end
			cpu16_pkg::op_rr: begin
				if (instr[4:0] == cpu16_pkg::funct_and) begin
					reg_write = 1'b1;
					alu_op    = cpu16_pkg::alu_and;
				end
				else if (instr[4:0] == cpu16_pkg::funct_or) begin
					reg_write = 1'b1;
					alu_op    = cpu16_pkg::alu_or;
				end
				// JR, CMP, MFPC and the rest fall through as NOP
			end
			cpu16_pkg::op_move: begin
				if (instr[4:0] == cpu16_pkg::funct_move) begin // rx = ry
					reg_write = 1'b1;
					alu_op    = cpu16_pkg::alu_pass_b;
				end
			end
			cpu16_pkg::op_shift: begin
				if (instr[1:0] == cpu16_pkg::funct_sll) begin
					// ry on port 1 feeds the shifter input
					read_addr1  = instr[7:5];
					reg_write   = 1'b1;
					alu_op      = cpu16_pkg::alu_sll;
					alu_src_imm = 1'b1;
					// Shift field of 0 encodes 8
					imm         = (instr[4:2] == 3'd0) ? 16'd8 : {13'd0, instr[4:2]};
				end
			end
			cpu16_pkg::op_lw: begin
				reg_addr    = instr[7:5]; // Load target is ry
				reg_write   = 1'b1;
				mem_read    = 1'b1;
				alu_src_imm = 1'b1;
				imm         = {{11{instr[4]}}, instr[4:0]};
			end
			cpu16_pkg::op_sw: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = {{11{instr[4]}}, instr[4:0]};
			end
			cpu16_pkg::op_b: begin
				branch = cpu16_pkg::br_always;
				imm    = {{5{instr[10]}}, instr[10:0]}; // simm11
			end
			cpu16_pkg::op_bnez: begin
				branch = cpu16_pkg::br_nez; // Tests rx via port 1
				imm    = {{8{instr[7]}}, instr[7:0]};
			end
			cpu16_pkg::op_nop: begin
				// Nothing to enable
			end
			default: begin
				// Unsupported encodings keep the NOP defaults
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                              pclk,
	input  wire                              arst_n,
	input  wire [cpu16_pkg::reg_addr_w-1:0]  rd_addr1,
	input  wire [cpu16_pkg::reg_addr_w-1:0]  rd_addr2,
	output logic [15:0]                      rd_data1,
	output logic [15:0]                      rd_data2,
	input  wire                              wr_en,
	input  wire [cpu16_pkg::reg_addr_w-1:0]  wr_addr,
	input  wire [15:0]                       wr_data
);

	localparam int num_regs = 2 ** cpu16_pkg::reg_addr_w;

	logic [15:0] regs [num_regs];

	// Asynchronous reads, old value during a same-cycle write
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= 16'h0000; // All registers start at zero
			end
		end
		else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: verif/cpu16_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_assertions (
	input wire                    pclk,
	input wire                    arst_n,
	input wire                    wb_cyc,
	input wire                    wb_stb,
	input wire                    wb_we,
	input wire [15:0]             wb_adr,
	input wire [15:0]             wb_dat_w,
	input wire                    wb_ack,
	input wire cpu16_pkg::state_e state
);

	int fail_count = 0; // Failures so far

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic master rules
	////////////////////////////////////////////////////////////////////////////

	stb_needs_cyc: assert property (@(posedge pclk) disable iff (!arst_n)
		wb_stb |-> wb_cyc)
	else begin
		$error("wb_stb high without wb_cyc");
		fail_count++;
	end

	// Request frozen until the slave acks
	req_held: assert property (@(posedge pclk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we))
	else begin
		$error("Request changed or dropped before wb_ack");
		fail_count++;
	end

	wdata_held: assert property (@(posedge pclk) disable iff (!arst_n)
		wb_stb && wb_we && !wb_ack |=> $stable(wb_dat_w)) // Write data only
	else begin
		$error("wb_dat_w changed before wb_ack");
		fail_count++;
	end

	idle_after_ack: assert property (@(posedge pclk) disable iff (!arst_n)
		wb_stb && wb_ack |=> !wb_stb)
	else begin
		$error("wb_stb still high in the cycle after wb_ack");
		fail_count++;
	end

	// Fetches are always reads
	fetch_reads: assert property (@(posedge pclk) disable iff (!arst_n)
		wb_stb && state == cpu16_pkg::st_fetch |-> !wb_we)
	else begin
		$error("Write request issued from the fetch state");
		fail_count++;
	end

	// Bus quiet while reset is held
	quiet_in_reset: assert property (@(posedge pclk)
		!arst_n |-> !wb_cyc && !wb_stb && !wb_we)
	else begin
		$error("Bus cycle during reset");
		fail_count++;
	end

endmodule

bind cpu_ctrl cpu16_assertions i_assertions (
	.pclk     (pclk),
	.arst_n   (arst_n),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_ack   (wb_ack),
	.state    (state)
);

`default_nettype wire

// File: verif/tb_cpu16.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu16;

	localparam logic [15:0] reset_pc   = 16'h0040; // Off zero on purpose
	localparam int          wait_limit = 24;       // Cycles per wait, max ack delay is 3

	typedef enum logic [1:0] {
		acc_none,
		acc_load,
		acc_store
	} access_e;

	// One executed instruction with its bus traffic
	typedef struct packed {
		logic [15:0] pc;   // Expected fetch address
		logic [15:0] word; // Instruction returned on fetch
		access_e     kind;
		logic [15:0] adr;  // Data address
		logic [15:0] data; // Load data returned or store data expected
	} row_t;

	logic        pclk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [15:0] wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;

	row_t program_rows [$];

	cpu16_top #(
		.RESET_PC (reset_pc)
	) i_dut (
		.pclk     (pclk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		pclk = 1'b0;
	end

	always #2 pclk = ~pclk; // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp));
		end
	endtask

	// Bound checkers inside the controller
	always @(negedge pclk) begin
		if (i_dut.u_ctrl.i_assertions.fail_count != 0) begin
			abort_run("A Wishbone protocol assertion fired");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program table, results worked out by hand, r7 is the 0x80 data base
	////////////////////////////////////////////////////////////////////////////

	function automatic void add_row(input logic [15:0] pc, input logic [15:0] word,
		input access_e kind, input logic [15:0] adr, input logic [15:0] data);
		row_t r;
		r.pc   = pc;
		r.word = word;
		r.kind = kind;
		r.adr  = adr;
		r.data = data;
		program_rows.push_back(r);
	endfunction

	function automatic void load_program();
		add_row(16'h0040, 16'h6935, acc_none, 16'h0000, 16'h0000);  // LI r1, 0x35
		add_row(16'h0041, 16'h6AC3, acc_none, 16'h0000, 16'h0000);  // LI r2, 0xC3, zero-extended
		add_row(16'h0042, 16'h6F80, acc_none, 16'h0000, 16'h0000);  // LI r7, 0x80
		add_row(16'h0043, 16'h49FD, acc_none, 16'h0000, 16'h0000);  // ADDIU r1, -3 -> 0x32
		add_row(16'h0044, 16'hE14D, acc_none, 16'h0000, 16'h0000);  // ADDU r3 = r1 + r2 -> 0xF5
		add_row(16'h0045, 16'hE153, acc_none, 16'h0000, 16'h0000);  // SUBU r4 = r1 - r2 -> 0xFF6F
		add_row(16'h0046, 16'hDF60, acc_store, 16'h0080, 16'h00F5); // SW r3, 0(r7)
		add_row(16'h0047, 16'hDF81, acc_store, 16'h0081, 16'hFF6F); // SW r4, 1(r7)
		add_row(16'h0048, 16'hEB4C, acc_none, 16'h0000, 16'h0000);  // AND r3, r2 -> 0xC1
		add_row(16'h0049, 16'hEC4D, acc_none, 16'h0000, 16'h0000);  // OR r4, r2 -> 0xFFEF
		add_row(16'h004A, 16'hDF62, acc_store, 16'h0082, 16'h00C1); // SW r3, 2(r7)
		add_row(16'h004B, 16'hDF83, acc_store, 16'h0083, 16'hFFEF); // SW r4, 3(r7)
		add_row(16'h004C, 16'h7D20, acc_none, 16'h0000, 16'h0000);  // MOVE r5, r1
		add_row(16'h004D, 16'h362C, acc_none, 16'h0000, 16'h0000);  // SLL r6, r1, 3 -> 0x190
		add_row(16'h004E, 16'h31A0, acc_none, 16'h0000, 16'h0000);  // SLL r1, r5, field 0 = 8
		add_row(16'h004F, 16'hDFBF, acc_store, 16'h007F, 16'h0032); // SW r5, -1(r7)
		add_row(16'h0050, 16'hDFC4, acc_store, 16'h0084, 16'h0190); // SW r6, 4(r7)
		add_row(16'h0051, 16'hDF25, acc_store, 16'h0085, 16'h3200); // SW r1, 5(r7)
		add_row(16'h0052, 16'h9F5E, acc_load, 16'h007E, 16'hA5C3);  // LW r2, -2(r7)
		add_row(16'h0053, 16'h9F70, acc_load, 16'h0070, 16'h5A0F);  // LW r3, -16(r7)
		add_row(16'h0054, 16'hDF5D, acc_store, 16'h007D, 16'hA5C3); // SW r2, -3(r7)
		add_row(16'h0055, 16'hDF66, acc_store, 16'h0086, 16'h5A0F); // SW r3, 6(r7)
		add_row(16'h0056, 16'h0800, acc_none, 16'h0000, 16'h0000);  // NOP
		add_row(16'h0057, 16'hFFFF, acc_none, 16'h0000, 16'h0000);  // Unknown major opcode
		add_row(16'h0058, 16'hEA00, acc_none, 16'h0000, 16'h0000);  // JR r2, dropped
		add_row(16'h0059, 16'h3246, acc_none, 16'h0000, 16'h0000);  // SRL r2, dropped
		add_row(16'h005A, 16'hDF47, acc_store, 16'h0087, 16'hA5C3); // r2 untouched
		add_row(16'h005B, 16'h2805, acc_none, 16'h0000, 16'h0000);  // BNEZ r0, +5 not taken
		add_row(16'h005C, 16'h2D02, acc_none, 16'h0000, 16'h0000);  // BNEZ r5, +2 taken
		add_row(16'h005F, 16'h1003, acc_none, 16'h0000, 16'h0000);  // B +3
		add_row(16'h0063, 16'h6E02, acc_none, 16'h0000, 16'h0000);  // LI r6, 2
		add_row(16'h0064, 16'h4EFF, acc_none, 16'h0000, 16'h0000);  // ADDIU r6, -1 -> 1
		add_row(16'h0065, 16'h2EFE, acc_none, 16'h0000, 16'h0000);  // BNEZ r6, -2 back
		add_row(16'h0064, 16'h4EFF, acc_none, 16'h0000, 16'h0000);  // ADDIU r6, -1 -> 0
		add_row(16'h0065, 16'h2EFE, acc_none, 16'h0000, 16'h0000);  // Falls through
		add_row(16'h0066, 16'hDFC8, acc_store, 16'h0088, 16'h0000); // SW r6, 8(r7)
		add_row(16'h0067, 16'h17FF, acc_none, 16'h0000, 16'h0000);  // B -1, spins on itself
		add_row(16'h0067, 16'h17FF, acc_none, 16'h0000, 16'h0000);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Wishbone slave side
	////////////////////////////////////////////////////////////////////////////

	// Sample on the falling edge, requests only change on the rising one
	task automatic wait_for_request(input string what);
		int cycles;
		cycles = 0;
		@(negedge pclk);
		while (!wb_stb) begin
			if (cycles == wait_limit) begin
				abort_run($sformatf("Timed out at %0t waiting for the %s request", $time, what));
			end
			cycles++;
			@(negedge pclk);
		end
		check("wb_cyc", 16'(wb_cyc), 16'h0001);
	endtask

	task automatic ack_request(input logic [15:0] rdata);
		int delay;
		delay = $urandom_range(3, 0); // Back-pressure
		repeat (delay) begin
			@(posedge pclk);
		end
		@(posedge pclk);
		wb_ack   <= 1'b1;
		wb_dat_r <= rdata;
		@(posedge pclk);
		wb_ack   <= 1'b0;
		wb_dat_r <= 16'h0000;
	endtask

	task automatic serve_fetch(input row_t r);
		wait_for_request("fetch");
		check("wb_we", 16'(wb_we), 16'h0000);
		check("wb_adr", wb_adr, r.pc);
		ack_request(r.word);
	endtask

	task automatic serve_data(input row_t r);
		if (r.kind == acc_load) begin
			wait_for_request("load");
			check("wb_we", 16'(wb_we), 16'h0000);
			check("wb_adr", wb_adr, r.adr);
			ack_request(r.data);
		end
		else if (r.kind == acc_store) begin
			wait_for_request("store");
			check("wb_we", 16'(wb_we), 16'h0001);
			check("wb_adr", wb_adr, r.adr);
			check("wb_dat_w", wb_dat_w, r.data);
			ack_request(16'h0000);
		end
		// No access expected, next request must be a fetch
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h7dd2)); // Seed once
		arst_n   = 1'b0;
		wb_ack   = 1'b0;
		wb_dat_r = 16'h0000;
		load_program();

		repeat (4) begin // Bus must stay idle in reset
			@(negedge pclk);
			check("wb_cyc", 16'(wb_cyc), 16'h0000);
		end
		@(posedge pclk);
		arst_n <= 1'b1;

		foreach (program_rows[i]) begin
			serve_fetch(program_rows[i]);
			serve_data(program_rows[i]);
		end

		@(negedge pclk); // Let the last handshake settle
		if (i_dut.u_ctrl.i_assertions.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end
		else begin
			abort_run("A Wishbone protocol assertion fired");
		end
	end

endmodule

`default_nettype wire
